/* hdl/cpri_frame_pkg.sv */
/*
 * frame geometry, header field positions and header types of one CPRI symbol packet
 * imported by the header capture, the RE sequencer and the top level
 */
`default_nettype none

package cpri_frame_pkg;

    // --------------------
    // input stream and header
    localparam int WORD_W    = 64;
    localparam int HDR_WORDS = 4;
    localparam int HDR_CNT_W = $clog2(HDR_WORDS);
    // agc occupies header words 2 and 3
    localparam int AGC_W     = 2 * WORD_W;

    // --------------------
    // symbol geometry
    localparam int RE_PER_PRB    = 12;
    localparam int PRB_PER_SYMB  = 132;
    localparam int RE_PER_SYMB   = RE_PER_PRB * PRB_PER_SYMB;
    // 1584 samples, 8 per 7 words
    localparam int PAYLOAD_WORDS = 1386;
    localparam int RE_CNT_W      = $clog2(RE_PER_PRB);
    localparam int PRB_CNT_W     = $clog2(PRB_PER_SYMB);
    localparam int RE_ADDR_W     = $clog2(RE_PER_SYMB);

    // --------------------
    // field positions in info 0
    localparam int PKG_TYPE_LSB = 36;
    localparam int PKG_TYPE_W   = 4;
    localparam int CELL_IDX_BIT = 19;
    localparam int SLOT_IDX_LSB = 12;
    localparam int SLOT_IDX_W   = 7;
    localparam int SYMB_IDX_LSB = 8;
    localparam int SYMB_IDX_W   = 4;

    typedef logic [RE_ADDR_W-1:0] re_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } hdr_state_e;

    typedef struct packed {
        logic [WORD_W-1:0]     info_0;
        logic [WORD_W-1:0]     info_1;
        logic [PKG_TYPE_W-1:0] pkg_type;
        logic [SLOT_IDX_W-1:0] slot_idx;
        logic [SYMB_IDX_W-1:0] symb_idx;
        logic                  cell_idx;
        logic [AGC_W-1:0]      agc;
    } hdr_fields_t;

endpackage

`default_nettype wire

/* hdl/cpri_iq_pkg.sv */
/*
 * compressed sample, shift and antenna-lane types for the payload path
 * compile after the frame package, which provides the RE address type
 */
`default_nettype none

package cpri_iq_pkg;

    // --------------------
    // lanes and sample packing
    localparam int ANT     = 4;
    localparam int LANE_W  = 16;
    localparam int PKG_W   = 14;
    localparam int MANT_W  = 7;
    localparam int SHIFT_W = 4;
    localparam int IQ_W    = 2 * LANE_W;

    // 7 words of 16-bit slices carry 8 samples of 14 bits
    localparam int GROUP_WORDS   = 7;
    localparam int GROUP_SAMPLES = 8;
    localparam int PHASE_W       = $clog2(GROUP_SAMPLES);

    // one shift nibble per prb, repeating every 8 prbs
    localparam int AGC_NIBBLES = 8;
    localparam int NIB_W       = $clog2(AGC_NIBBLES);

    typedef logic [ANT-1:0][PKG_W-1:0]   cpmr_pkg_t;
    typedef logic [ANT-1:0][SHIFT_W-1:0] shift_vec_t;
    // per lane: I in the upper half, Q in the lower half
    typedef logic [ANT-1:0][IQ_W-1:0]    iq_word_t;

    typedef struct packed {
        cpri_frame_pkg::re_addr_t addr;
        iq_word_t                 data;
        logic                     last;
    } iq_beat_t;

endpackage

`default_nettype wire

/* hdl/cpri_header_capture.sv */
/*
 * packet FSM: stores the four header words after a start of packet and decodes
 * the info 0 fields, then enables the payload path until the symbol is done
 */
`timescale 1ns/1ns
`default_nettype none

module cpri_header_capture
    import cpri_frame_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    input  wire logic [WORD_W-1:0] i_rx_data,
    input  wire logic              i_rx_vld,
    input  wire logic              i_rx_sop,
    input  wire logic              i_symb_done,
    output hdr_fields_t            o_hdr,
    output logic                   o_hdr_vld,
    output logic                   o_payload_en
);

    hdr_state_e             state;
    logic [HDR_CNT_W-1:0]   word_cnt;
    hdr_fields_t            hdr_q;
    logic                   sop_word;
    logic                   hdr_word;
    logic                   hdr_last;

    // sop wins over everything, even mid-payload
    assign sop_word = i_rx_vld && i_rx_sop;
    assign hdr_word = i_rx_vld && !i_rx_sop && (state == HEADER);
    assign hdr_last = hdr_word && (word_cnt == HDR_CNT_W'(HDR_WORDS - 1));

    // --------------------
    // state and word count
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= IDLE;
            word_cnt  <= '0;
            o_hdr_vld <= 1'b0;
        end else if (sop_word) begin
            state     <= HEADER;
            word_cnt  <= HDR_CNT_W'(1);
            o_hdr_vld <= 1'b0;
        end else begin
            case (state)
                HEADER: begin
                    if (hdr_word) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    if (hdr_last) begin
                        state     <= PAYLOAD;
                        o_hdr_vld <= 1'b1;
                    end
                end
                PAYLOAD: begin
                    if (i_symb_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // --------------------
    // header word storage
    always_ff @(posedge i_clk) begin
        if (sop_word) begin
            hdr_q.info_0 <= i_rx_data;
        end else if (hdr_word) begin
            case (word_cnt)
                HDR_CNT_W'(1): hdr_q.info_1 <= i_rx_data;
                HDR_CNT_W'(2): hdr_q.agc[WORD_W-1:0] <= i_rx_data;
                default: begin
                    hdr_q.agc[AGC_W-1:WORD_W] <= i_rx_data;
                    // info 0 is already held, decode along with the last word
                    hdr_q.pkg_type <= hdr_q.info_0[PKG_TYPE_LSB +: PKG_TYPE_W];
                    hdr_q.slot_idx <= hdr_q.info_0[SLOT_IDX_LSB +: SLOT_IDX_W];
                    hdr_q.symb_idx <= hdr_q.info_0[SYMB_IDX_LSB +: SYMB_IDX_W];
                    hdr_q.cell_idx <= hdr_q.info_0[CELL_IDX_BIT];
                end
            endcase
        end
    end

    assign o_hdr        = hdr_q;
    assign o_payload_en = (state == PAYLOAD);

endmodule

`default_nettype wire

/* hdl/cpri_iq_bit_unpack.sv */
/*
 * repacks the 16-bit lane slices of payload words into 14-bit samples per lane
 * ready drops for one cycle after every seventh word to emit the eighth sample
 */
`timescale 1ns/1ns
`default_nettype none

module cpri_iq_bit_unpack
    import cpri_frame_pkg::*;
    import cpri_iq_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    input  wire logic [WORD_W-1:0] i_rx_data,
    input  wire logic              i_rx_vld,
    input  wire logic              i_payload_en,
    output logic                   o_rx_ready,
    output cpmr_pkg_t              o_pkg,
    output logic                   o_pkg_vld
);

    logic [PHASE_W-1:0] phase;
    logic [WORD_W-1:0]  prev_word;
    logic               accept;
    logic               drain;

    // --------------------
    // slice joining
    // phase k takes 2k unused top bits of the previous slice
    // and fills up with the low bits of the current one
    function automatic logic [PKG_W-1:0] join_slices(
        input logic [LANE_W-1:0]  cur,
        input logic [LANE_W-1:0]  prev,
        input logic [PHASE_W-1:0] ph
    );
        logic [2*LANE_W-1:0] pair;
        pair = {cur, prev} >> (LANE_W - ph * (LANE_W - PKG_W));
        return pair[PKG_W-1:0];
    endfunction

    // phase 7 drains the held word, no new word taken
    assign drain      = (phase == PHASE_W'(GROUP_WORDS));
    assign o_rx_ready = !drain;
    assign accept     = i_rx_vld && o_rx_ready && i_payload_en;

    // --------------------
    // group phase
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phase     <= '0;
            o_pkg_vld <= 1'b0;
        end else begin
            o_pkg_vld <= accept || drain;
            if (drain || !i_payload_en) begin
                phase <= '0;
            end else if (accept) begin
                phase <= phase + 1'b1;
            end
        end
    end

    // --------------------
    // sample registers
    always_ff @(posedge i_clk) begin
        if (accept || drain) begin
            for (int a = 0; a < ANT; a++) begin
                o_pkg[a] <= join_slices(i_rx_data[a*LANE_W +: LANE_W],
                                        prev_word[a*LANE_W +: LANE_W],
                                        phase);
            end
        end
        if (accept) begin
            prev_word <= i_rx_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/cpri_re_sequencer.sv */
/*
 * numbers the samples of one symbol: RE within PRB, PRB within symbol and address
 * picks each lane's AGC shift for the current PRB and flags the last sample
 */
`timescale 1ns/1ns
`default_nettype none

module cpri_re_sequencer
    import cpri_frame_pkg::*;
    import cpri_iq_pkg::*;
(
    input  wire logic             i_clk,
    input  wire logic             i_reset,
    input  wire cpmr_pkg_t        i_pkg,
    input  wire logic             i_pkg_vld,
    input  wire logic [AGC_W-1:0] i_agc,
    output cpmr_pkg_t             o_pkg,
    output shift_vec_t            o_shift,
    output re_addr_t              o_addr,
    output logic                  o_last,
    output logic                  o_vld,
    output logic                  o_symb_done
);

    logic [RE_CNT_W-1:0]  re_cnt;
    logic [PRB_CNT_W-1:0] prb_cnt;
    re_addr_t             addr;
    logic                 re_end;
    logic                 addr_end;
    logic [NIB_W-1:0]     nib;
    shift_vec_t           shift_sel;

    assign re_end   = (re_cnt == RE_CNT_W'(RE_PER_PRB - 1));
    assign addr_end = (addr == RE_ADDR_W'(RE_PER_SYMB - 1));
    // prb mod 8, the nibble count is a power of two
    assign nib      = prb_cnt[NIB_W-1:0];

    // --------------------
    // shift select
    always_comb begin
        for (int a = 0; a < ANT; a++) begin
            shift_sel[a] = i_agc[a*AGC_NIBBLES*SHIFT_W + nib*SHIFT_W +: SHIFT_W];
        end
    end

    // --------------------
    // counters
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt  <= '0;
            prb_cnt <= '0;
            addr    <= '0;
        end else if (i_pkg_vld) begin
            if (addr_end) begin
                re_cnt  <= '0;
                prb_cnt <= '0;
                addr    <= '0;
            end else begin
                addr <= addr + 1'b1;
                if (re_end) begin
                    re_cnt  <= '0;
                    prb_cnt <= prb_cnt + 1'b1;
                end else begin
                    re_cnt <= re_cnt + 1'b1;
                end
            end
        end
    end

    // --------------------
    // output stage
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_vld       <= 1'b0;
            o_last      <= 1'b0;
            o_symb_done <= 1'b0;
        end else begin
            o_vld       <= i_pkg_vld;
            o_last      <= i_pkg_vld && addr_end;
            o_symb_done <= i_pkg_vld && addr_end;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_pkg_vld) begin
            o_pkg   <= i_pkg;
            o_shift <= shift_sel;
            o_addr  <= addr;
        end
    end

endmodule

`default_nettype wire

/* hdl/cpri_decompress.sv */
/*
 * expands the 7-bit I and Q mantissas of every lane to 16 bits with the PRB shift
 * and registers them as one output beat with address and last flag
 */
`timescale 1ns/1ns
`default_nettype none

module cpri_decompress
    import cpri_frame_pkg::*;
    import cpri_iq_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset,
    input  wire cpmr_pkg_t  i_pkg,
    input  wire shift_vec_t i_shift,
    input  wire re_addr_t   i_addr,
    input  wire logic       i_last,
    input  wire logic       i_vld,
    output iq_beat_t        o_iq,
    output logic            o_iq_vld
);

    iq_word_t expanded;
    iq_word_t data_q;
    re_addr_t addr_q;
    logic     last_q;

    // sign-extend, shift left, keep the low 16 bits
    function automatic logic [LANE_W-1:0] expand(
        input logic [MANT_W-1:0]  mant,
        input logic [SHIFT_W-1:0] shift
    );
        logic [LANE_W-1:0] wide;
        wide = {{(LANE_W - MANT_W){mant[MANT_W-1]}}, mant};
        return wide << shift;
    endfunction

    always_comb begin
        for (int a = 0; a < ANT; a++) begin
            expanded[a] = {expand(i_pkg[a][PKG_W-1:MANT_W], i_shift[a]),
                           expand(i_pkg[a][MANT_W-1:0], i_shift[a])};
        end
    end

    // --------------------
    // output beat
    always_ff @(posedge i_clk) begin
        if (i_vld) begin
            data_q <= expanded;
            addr_q <= i_addr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_iq_vld <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            o_iq_vld <= i_vld;
            last_q   <= i_vld && i_last;
        end
    end

    assign o_iq = '{addr: addr_q, data: data_q, last: last_q};

endmodule

`default_nettype wire

/* hdl/cpri_unpack_top.sv */
/*
 * CPRI symbol unpacker: header capture, bit unpack, RE sequencing, decompression
 * one packet per sop, four antenna lanes of I/Q out with RE address
 */
`timescale 1ns/1ns
`default_nettype none

module cpri_unpack_top
    import cpri_frame_pkg::*;
    import cpri_iq_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    input  wire logic [WORD_W-1:0] i_rx_data,
    input  wire logic              i_rx_vld,
    input  wire logic              i_rx_sop,
    output logic                   o_rx_ready,
    output hdr_fields_t            o_hdr,
    output logic                   o_hdr_vld,
    output iq_beat_t               o_iq,
    output logic                   o_iq_vld
);

    logic       payload_en;
    logic       symb_done;
    cpmr_pkg_t  unpack_pkg;
    logic       unpack_vld;
    cpmr_pkg_t  seq_pkg;
    shift_vec_t seq_shift;
    re_addr_t   seq_addr;
    logic       seq_last;
    logic       seq_vld;

    // --------------------
    // packet control
    cpri_header_capture u_header_capture (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_data    (i_rx_data),
        .i_rx_vld     (i_rx_vld),
        .i_rx_sop     (i_rx_sop),
        .i_symb_done  (symb_done),
        .o_hdr        (o_hdr),
        .o_hdr_vld    (o_hdr_vld),
        .o_payload_en (payload_en)
    );

    // --------------------
    // payload pipeline
    cpri_iq_bit_unpack u_iq_bit_unpack (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_data    (i_rx_data),
        .i_rx_vld     (i_rx_vld),
        .i_payload_en (payload_en),
        .o_rx_ready   (o_rx_ready),
        .o_pkg        (unpack_pkg),
        .o_pkg_vld    (unpack_vld)
    );

    cpri_re_sequencer u_re_sequencer (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_pkg       (unpack_pkg),
        .i_pkg_vld   (unpack_vld),
        .i_agc       (o_hdr.agc),
        .o_pkg       (seq_pkg),
        .o_shift     (seq_shift),
        .o_addr      (seq_addr),
        .o_last      (seq_last),
        .o_vld       (seq_vld),
        .o_symb_done (symb_done)
    );

    cpri_decompress u_decompress (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_pkg    (seq_pkg),
        .i_shift  (seq_shift),
        .i_addr   (seq_addr),
        .i_last   (seq_last),
        .i_vld    (seq_vld),
        .o_iq     (o_iq),
        .o_iq_vld (o_iq_vld)
    );

endmodule

`default_nettype wire

/* include/tb_cpri_ref.svh */
/*
 * testbench reference model with the LCG, the packet builder and the expected I/Q
 * included inside the testbench module after the package imports
 */
`ifndef TB_CPRI_REF_SVH
`define TB_CPRI_REF_SVH

logic [31:0]       lcg_state;
logic [WORD_W-1:0] hdr_words [HDR_WORDS];
logic [WORD_W-1:0] pay_words [PAYLOAD_WORDS];

// --------------------
// random source
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic draw_rand(output logic [31:0] r);
    lcg_state = lcg_next(lcg_state);
    r = lcg_state;
endtask

task automatic draw_word(output logic [63:0] w);
    logic [31:0] lo;
    logic [31:0] hi;
    draw_rand(lo);
    draw_rand(hi);
    w = {hi, lo};
endtask

// random header and payload with the fields at their info 0 positions
task automatic build_packet(input logic [3:0] pkg_type, input logic [6:0] slot,
                            input logic [3:0] symb, input logic cell_bit,
                            input logic [3:0] shift_set);
    logic [63:0] w;
    for (int i = 0; i < HDR_WORDS; i++) begin
        draw_word(w);
        hdr_words[i] = w;
    end
    hdr_words[0][39:36] = pkg_type;
    hdr_words[0][19]    = cell_bit;
    hdr_words[0][18:12] = slot;
    hdr_words[0][11:8]  = symb;
    // forcing high shift bits makes large mantissas overflow 16 bits
    for (int n = 0; n < 16; n++) begin
        hdr_words[2][4*n +: 4] = hdr_words[2][4*n +: 4] | shift_set;
        hdr_words[3][4*n +: 4] = hdr_words[3][4*n +: 4] | shift_set;
    end
    for (int i = 0; i < PAYLOAD_WORDS; i++) begin
        draw_word(w);
        pay_words[i] = w;
    end
endtask

// --------------------
// expected values
function automatic logic [15:0] expand_ref(input logic [6:0] mant, input logic [3:0] shift);
    int value;
    value = int'(mant);
    if (mant[6]) begin
        value = value - 128;
    end
    value = value * (1 << shift);
    return value[15:0];
endfunction

// 7 lane slices with word 0 lowest hold 8 samples of 14 bits
function automatic logic [13:0] sample_ref(input int addr, input int a);
    logic [111:0] bits;
    int           g;
    int           j;
    g = addr / 8;
    j = addr % 8;
    for (int w = 0; w < 7; w++) begin
        bits[16*w +: 16] = pay_words[7*g + w][16*a +: 16];
    end
    return bits[14*j +: 14];
endfunction

function automatic logic [3:0] agc_shift(input int a, input int prb);
    logic [127:0] agc;
    agc = {hdr_words[3], hdr_words[2]};
    return agc[32*a + 4*(prb % 8) +: 4];
endfunction

function automatic iq_word_t expected_data(input int addr);
    iq_word_t    d;
    logic [13:0] s;
    logic [3:0]  sh;
    for (int a = 0; a < 4; a++) begin
        s = sample_ref(addr, a);
        sh = agc_shift(a, addr / 12);
        d[a] = {expand_ref(s[13:7], sh), expand_ref(s[6:0], sh)};
    end
    return d;
endfunction

`endif

/* tests/tb_cpri_unpack_top.sv */
/*
 * testbench for the CPRI unpacker with two packets of random payload and AGC
 * checks the header, the ready gap and every output beat against a reference
 */
`timescale 1ns/1ns
`default_nettype none

module tb_cpri_unpack_top
    import cpri_frame_pkg::*;
    import cpri_iq_pkg::*;
();

    logic              i_clk = 1'b0;
    logic              i_reset;
    logic [WORD_W-1:0] i_rx_data;
    logic              i_rx_vld;
    logic              i_rx_sop;
    logic              o_rx_ready;
    hdr_fields_t       o_hdr;
    logic              o_hdr_vld;
    iq_beat_t          o_iq;
    logic              o_iq_vld;

    int       stim_errs = 0;
    int       timed_out = 0;
    int       cmp_errs = 0;
    int       cmp_fail;
    int       beat_idx = 0;
    int       beat_total = 0;
    int       pkts_done = 0;
    iq_word_t cmp_exp;

    `include "tb_cpri_ref.svh"

    always #50 i_clk = ~i_clk;

    cpri_unpack_top i_cpri_unpack_top (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_data  (i_rx_data),
        .i_rx_vld   (i_rx_vld),
        .i_rx_sop   (i_rx_sop),
        .o_rx_ready (o_rx_ready),
        .o_hdr      (o_hdr),
        .o_hdr_vld  (o_hdr_vld),
        .o_iq       (o_iq),
        .o_iq_vld   (o_iq_vld)
    );

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp, output int fails);
        fails = 0;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            fails = 1;
        end
    endtask

    task automatic report_test(input string name, input int mark);
        int errs;
        errs = stim_errs + cmp_errs - mark;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, errs);
        end
    endtask

    // --------------------
    // output comparison in address order
    always @(negedge i_clk) begin
        if (!i_reset && o_iq_vld) begin
            cmp_exp = expected_data(beat_idx);
            check_value("beat address", 128'(o_iq.addr), 128'(beat_idx), cmp_fail);
            cmp_errs = cmp_errs + cmp_fail;
            check_value($sformatf("iq data at address %0d", beat_idx), o_iq.data, cmp_exp,
                        cmp_fail);
            cmp_errs = cmp_errs + cmp_fail;
            check_value($sformatf("last flag at address %0d", beat_idx), 128'(o_iq.last),
                        128'(beat_idx == RE_PER_SYMB - 1), cmp_fail);
            cmp_errs = cmp_errs + cmp_fail;
            beat_total = beat_total + 1;
            if (beat_idx == RE_PER_SYMB - 1) begin
                beat_idx = 0;
                pkts_done = pkts_done + 1;
            end else begin
                beat_idx = beat_idx + 1;
            end
        end
    end

    // --------------------
    // stimulus
    task automatic send_header();
        logic [31:0] r;
        for (int w = 0; w < HDR_WORDS; w++) begin
            @(negedge i_clk);
            draw_rand(r);
            // occasional gap between header words
            if (w > 0 && r[30:28] == 3'd0) begin
                i_rx_vld = 1'b0;
                i_rx_sop = 1'b0;
                @(negedge i_clk);
            end
            i_rx_data = hdr_words[w];
            i_rx_vld  = 1'b1;
            i_rx_sop  = (w == 0);
        end
    endtask

    task automatic run_packet(input int pkt_no, input logic [3:0] pkg_type,
                              input logic [6:0] slot, input logic [3:0] symb,
                              input logic cell_bit, input logic [3:0] shift_set);
        int          mark;
        int          fails;
        int          word_idx;
        int          cycles;
        int          low_cnt;
        bit          prev_acc;
        logic        exp_ready;
        logic [31:0] r;
        logic [63:0] w;
        build_packet(pkg_type, slot, symb, cell_bit, shift_set);
        mark = stim_errs + cmp_errs;
        send_header();
        @(negedge i_clk);
        i_rx_vld = 1'b0;
        i_rx_sop = 1'b0;
        check_value("hdr_vld", 128'(o_hdr_vld), 128'(1'b1), fails);
        stim_errs += fails;
        check_value("info_0", 128'(o_hdr.info_0), 128'(hdr_words[0]), fails);
        stim_errs += fails;
        check_value("info_1", 128'(o_hdr.info_1), 128'(hdr_words[1]), fails);
        stim_errs += fails;
        check_value("agc", o_hdr.agc, {hdr_words[3], hdr_words[2]}, fails);
        stim_errs += fails;
        check_value("pkg_type", 128'(o_hdr.pkg_type), 128'(pkg_type), fails);
        stim_errs += fails;
        check_value("slot_idx", 128'(o_hdr.slot_idx), 128'(slot), fails);
        stim_errs += fails;
        check_value("symb_idx", 128'(o_hdr.symb_idx), 128'(symb), fails);
        stim_errs += fails;
        check_value("cell_idx", 128'(o_hdr.cell_idx), 128'(cell_bit), fails);
        stim_errs += fails;
        report_test($sformatf("header_%0d", pkt_no), mark);

        mark = stim_errs + cmp_errs;
        word_idx = 0;
        cycles = 0;
        low_cnt = 0;
        prev_acc = 1'b0;
        // one more pass after the last word covers its ready gap
        while ((word_idx < PAYLOAD_WORDS || prev_acc) && cycles < 3 * PAYLOAD_WORDS) begin
            @(negedge i_clk);
            cycles++;
            exp_ready = !(prev_acc && (word_idx % GROUP_WORDS == 0));
            check_value("rx ready", 128'(o_rx_ready), 128'(exp_ready), fails);
            stim_errs += fails;
            draw_rand(r);
            prev_acc = 1'b0;
            if (!o_rx_ready) begin
                // junk word offered in the gap must be dropped
                low_cnt++;
                draw_word(w);
                i_rx_data = w;
                i_rx_vld  = 1'b1;
            end else if (word_idx >= PAYLOAD_WORDS || r[31:29] == 3'd0) begin
                i_rx_vld = 1'b0;
            end else begin
                i_rx_data = pay_words[word_idx];
                i_rx_vld  = 1'b1;
                word_idx++;
                prev_acc  = 1'b1;
            end
        end
        @(negedge i_clk);
        i_rx_vld = 1'b0;
        if (word_idx < PAYLOAD_WORDS) begin
            $display("timeout: packet %0d stalled after %0d payload words", pkt_no, word_idx);
            timed_out++;
            return;
        end
        check_value("ready low cycles", 128'(low_cnt), 128'(PAYLOAD_WORDS / GROUP_WORDS), fails);
        stim_errs += fails;

        cycles = 0;
        while (pkts_done < pkt_no && cycles < 20) begin
            @(negedge i_clk);
            cycles++;
        end
        if (pkts_done < pkt_no) begin
            $display("timeout: packet %0d stopped at beat %0d of %0d", pkt_no, beat_idx,
                     RE_PER_SYMB);
            timed_out++;
            return;
        end
        repeat (4) @(negedge i_clk);
        check_value("beats after last", 128'(beat_idx), 128'(0), fails);
        stim_errs += fails;
        report_test($sformatf("payload_%0d", pkt_no), mark);
    endtask

    initial begin
        int mark;
        int fails;
        int total;
        i_reset   = 1'b1;
        i_rx_data = '0;
        i_rx_vld  = 1'b0;
        i_rx_sop  = 1'b0;
        lcg_state = 32'hde41;
        repeat (2) @(negedge i_clk);
        i_reset = 1'b0;

        mark = stim_errs + cmp_errs;
        check_value("iq_vld after reset", 128'(o_iq_vld), 128'(1'b0), fails);
        stim_errs += fails;
        check_value("hdr_vld after reset", 128'(o_hdr_vld), 128'(1'b0), fails);
        stim_errs += fails;
        check_value("iq last after reset", 128'(o_iq.last), 128'(1'b0), fails);
        stim_errs += fails;
        check_value("rx ready after reset", 128'(o_rx_ready), 128'(1'b1), fails);
        stim_errs += fails;
        report_test("reset", mark);

        run_packet(1, 4'h5, 7'd37, 4'd9, 1'b1, 4'h0);
        // second packet uses shifts of 8 and more
        if (timed_out == 0) begin
            run_packet(2, 4'ha, 7'd102, 4'd13, 1'b0, 4'h8);
        end

        total = stim_errs + cmp_errs;
        $display("beats checked %0d, errors %0d, timeouts %0d", beat_total, total, timed_out);
        if (timed_out != 0 || total != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpri_unpack_top.f */
+incdir+include
hdl/cpri_frame_pkg.sv
hdl/cpri_iq_pkg.sv
hdl/cpri_header_capture.sv
hdl/cpri_iq_bit_unpack.sv
hdl/cpri_re_sequencer.sv
hdl/cpri_decompress.sv
hdl/cpri_unpack_top.sv
tests/tb_cpri_unpack_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the CPRI unpacker testbench with Verilator and runs it
# exit status is 0 only when the simulation reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 \
    --top-module tb_cpri_unpack_top \
    -f cpri_unpack_top.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cpri_unpack_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Verification passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
